//--- mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

	////////////////////////////////////////////////////////////
	// data and address widths
	////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  byte_sel_t;
	typedef logic [4:0]  reg_addr_t;

	// memory operations seen by the stage
	typedef enum logic [3:0]
	{
		OP_NONE = 4'd0,
		OP_LB   = 4'd1,
		OP_LBU  = 4'd2,
		OP_LH   = 4'd3,
		OP_LHU  = 4'd4,
		OP_LW   = 4'd5,
		OP_SB   = 4'd6,
		OP_SH   = 4'd7,
		OP_SW   = 4'd8
	} mem_op_t;

	////////////////////////////////////////////////////////////
	// byte lanes, bit n enables byte n
	////////////////////////////////////////////////////////////

	localparam byte_sel_t SEL_NONE  = 4'b0000;
	localparam byte_sel_t SEL_ALL   = 4'b1111;

	// lowest lane pattern for each access size
	localparam byte_sel_t SEL_BYTE0 = 4'b0001;
	localparam byte_sel_t SEL_HALF0 = 4'b0011;

endpackage

`default_nettype wire

//--- mips_except_pkg.sv
`default_nettype none

package mips_except_pkg;

	// MIPS cause codes used by the stage
	typedef enum logic [4:0]
	{
		EXC_INT  = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12,
		EXC_TR   = 5'd13
	} exc_code_t;

	////////////////////////////////////////////////////////////
	// exceptions raised by earlier stages
	////////////////////////////////////////////////////////////

	typedef logic [3:0] exc_flags_t;

	localparam int unsigned FLAG_SYS = 0;
	localparam int unsigned FLAG_RI  = 1;
	localparam int unsigned FLAG_OV  = 2;
	localparam int unsigned FLAG_TR  = 3;

	////////////////////////////////////////////////////////////
	// status register fields
	////////////////////////////////////////////////////////////

	localparam int unsigned ST_IE    = 0;
	localparam int unsigned ST_EXL   = 1;
	localparam int unsigned ST_ERL   = 2;
	// interrupt mask starts here, one bit per line
	localparam int unsigned ST_IM_LO = 8;

endpackage

`default_nettype wire

//--- load_store_align.sv
`default_nettype none

module load_store_align
	import mips_mem_pkg::*;
(
	input  mem_op_t   op_i,
	input  addr_t     addr_i,
	input  word_t     reg2_i,
	input  word_t     rdata_i,
	output byte_sel_t sel_o,
	output word_t     store_data_o,
	output word_t     load_data_o,
	output logic      is_store_o,
	output logic      is_mem_o,
	output logic      misaligned_o
);

	logic [1:0] offset;
	logic       half_odd;
	logic       word_off;
	word_t      byte_shift;
	word_t      half_shift;
	logic [7:0] lane_byte;
	logic [15:0] lane_half;

	assign offset   = addr_i[1:0];
	assign half_odd = addr_i[0];
	assign word_off = |addr_i[1:0];

	// move the addressed lane down to bit 0
	assign byte_shift = rdata_i >> {offset, 3'b000};
	assign half_shift = rdata_i >> {offset[1], 4'b0000};
	assign lane_byte  = byte_shift[7:0];
	assign lane_half  = half_shift[15:0];

	assign is_mem_o   = (op_i != OP_NONE);
	assign is_store_o = (op_i == OP_SB) || (op_i == OP_SH) || (op_i == OP_SW);

	////////////////////////////////////////////////////////////
	// lane select and store data
	////////////////////////////////////////////////////////////

	always_comb
	begin
		sel_o        = SEL_NONE;
		store_data_o = '0;
		case (op_i)
			OP_LB, OP_LBU, OP_SB:
			begin
				sel_o        = SEL_BYTE0 << offset;
				store_data_o = {4{reg2_i[7:0]}};
			end
			OP_LH, OP_LHU, OP_SH:
			begin
				// odd halfword gets no lanes at all
				if (!half_odd)
				begin
					sel_o = SEL_HALF0 << {offset[1], 1'b0};
				end
				store_data_o = {2{reg2_i[15:0]}};
			end
			OP_LW, OP_SW:
			begin
				if (!word_off)
				begin
					sel_o = SEL_ALL;
				end
				store_data_o = reg2_i;
			end
			default:
			begin
				sel_o        = SEL_NONE;
				store_data_o = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// load extraction and extension
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op_i)
			OP_LB:   load_data_o = {{24{lane_byte[7]}}, lane_byte};
			OP_LBU:  load_data_o = {24'h000000, lane_byte};
			OP_LH:   load_data_o = {{16{lane_half[15]}}, lane_half};
			OP_LHU:  load_data_o = {16'h0000, lane_half};
			OP_LW:   load_data_o = rdata_i;
			default: load_data_o = '0;
		endcase
	end

	// halfwords need even addresses, words need a clean low pair
	always_comb
	begin
		case (op_i)
			OP_LH, OP_LHU, OP_SH: misaligned_o = half_odd;
			OP_LW, OP_SW:         misaligned_o = word_off;
			default:              misaligned_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- cp0_status_regs.sv
`default_nettype none

module cp0_status_regs
	import mips_mem_pkg::*;
	import mips_except_pkg::*;
#(
	parameter int unsigned NUM_HW_INT = 8
)
(
	input  wire   clk,
	input  wire   reset_i,
	input  logic  cfg_we_i,
	input  word_t cfg_data_i,
	output word_t status_o
);

	// only these bits exist in this design
	localparam word_t IM_BITS     = word_t'(((1 << NUM_HW_INT) - 1) << ST_IM_LO);
	localparam word_t CTRL_BITS   = word_t'((1 << ST_IE) | (1 << ST_EXL) | (1 << ST_ERL));
	localparam word_t STATUS_MASK = IM_BITS | CTRL_BITS;

	word_t status_q;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			status_q <= '0;
		end
		else if (cfg_we_i)
		begin
			status_q <= cfg_data_i & STATUS_MASK;
		end
	end

	assign status_o = status_q;

endmodule

`default_nettype wire

//--- except_resolve.sv
`default_nettype none

module except_resolve
	import mips_mem_pkg::*;
	import mips_except_pkg::*;
#(
	parameter int unsigned NUM_HW_INT = 8
)
(
	input  word_t                 status_i,
	input  logic [NUM_HW_INT-1:0] hw_int_i,
	input  exc_flags_t            exc_flags_i,
	input  logic                  misaligned_i,
	input  logic                  is_store_i,
	input  addr_t                 addr_i,
	output logic                  take_exc_o,
	output exc_code_t             exc_code_o,
	output addr_t                 badaddr_o
);

	logic int_masked;
	logic int_allowed;
	logic int_pending;

	// line must be unmasked and the core must not already be in a handler
	assign int_masked  = |(hw_int_i & status_i[ST_IM_LO +: NUM_HW_INT]);
	assign int_allowed = status_i[ST_IE] && !status_i[ST_EXL] && !status_i[ST_ERL];
	assign int_pending = int_masked && int_allowed;

	assign take_exc_o = int_pending || (|exc_flags_i) || misaligned_i;

	////////////////////////////////////////////////////////////
	// fixed priority, earliest match wins
	////////////////////////////////////////////////////////////

	always_comb
	begin
		exc_code_o = EXC_INT;
		badaddr_o  = '0;
		if (int_pending)
		begin
			exc_code_o = EXC_INT;
		end
		else if (exc_flags_i[FLAG_SYS])
		begin
			exc_code_o = EXC_SYS;
		end
		else if (exc_flags_i[FLAG_RI])
		begin
			exc_code_o = EXC_RI;
		end
		else if (exc_flags_i[FLAG_OV])
		begin
			exc_code_o = EXC_OV;
		end
		else if (exc_flags_i[FLAG_TR])
		begin
			exc_code_o = EXC_TR;
		end
		else if (misaligned_i)
		begin
			// address faults report the offending address
			exc_code_o = is_store_i ? EXC_ADES : EXC_ADEL;
			badaddr_o  = addr_i;
		end
	end

endmodule

`default_nettype wire

//--- mem_access_fsm.sv
`default_nettype none

module mem_access_fsm
	import mips_mem_pkg::*;
	import mips_except_pkg::*;
(
	input  wire       clk,
	input  wire       reset_i,

	// execute side
	input  logic      op_req_i,
	output logic      op_ack_o,
	input  reg_addr_t wd_i,
	input  logic      wreg_i,
	input  word_t     wdata_i,

	// lane logic
	input  logic      is_mem_i,
	input  logic      is_store_i,
	input  byte_sel_t sel_i,
	input  word_t     store_data_i,
	input  word_t     load_data_i,

	// exception resolver
	input  logic      take_exc_i,
	input  exc_code_t exc_code_i,
	input  addr_t     badaddr_i,

	input  addr_t     addr_i,

	// RAM side
	output logic      mem_req_o,
	input  logic      mem_ack_i,
	output addr_t     mem_addr_o,
	output logic      mem_we_o,
	output byte_sel_t mem_sel_o,
	output word_t     mem_data_o,
	input  word_t     mem_data_i,

	// results
	output reg_addr_t wd_o,
	output logic      wreg_o,
	output word_t     wdata_o,
	output logic      exc_o,
	output exc_code_t exc_code_o,
	output addr_t     badaddr_o,
	output word_t     rdata_o
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_MEM_REQ,
		ST_MEM_RELEASE,
		ST_DONE
	} state_t;

	state_t state;

	logic accept;
	logic start_mem;
	logic mem_grab;
	logic finish;
	logic is_load;

	assign accept    = (state == ST_IDLE) && op_req_i;
	// exceptions never reach the RAM
	assign start_mem = accept && is_mem_i && !take_exc_i;
	assign mem_grab  = (state == ST_MEM_REQ) && mem_ack_i;
	assign finish    = (state == ST_DONE) && !op_ack_o;
	assign is_load   = is_mem_i && !is_store_i;

	////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state     <= ST_IDLE;
			op_ack_o  <= 1'b0;
			mem_req_o <= 1'b0;
			mem_we_o  <= 1'b0;
			exc_o     <= 1'b0;
			wreg_o    <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (accept)
					begin
						exc_o <= take_exc_i;
						if (start_mem)
						begin
							mem_req_o <= 1'b1;
							mem_we_o  <= is_store_i;
							state     <= ST_MEM_REQ;
						end
						else
						begin
							state <= ST_DONE;
						end
					end
				end
				ST_MEM_REQ:
				begin
					// wait as long as the RAM needs
					if (mem_grab)
					begin
						mem_req_o <= 1'b0;
						mem_we_o  <= 1'b0;
						state     <= ST_MEM_RELEASE;
					end
				end
				ST_MEM_RELEASE:
				begin
					if (!mem_ack_i)
					begin
						state <= ST_DONE;
					end
				end
				ST_DONE:
				begin
					if (finish)
					begin
						op_ack_o <= 1'b1;
						wreg_o   <= wreg_i && !exc_o && !is_store_i;
					end
					else if (!op_req_i)
					begin
						op_ack_o <= 1'b0;
						state    <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// payload registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			exc_code_o <= exc_code_i;
			badaddr_o  <= badaddr_i;
		end
		if (start_mem)
		begin
			mem_addr_o <= addr_i;
			mem_sel_o  <= sel_i;
			mem_data_o <= store_data_i;
		end
		// read word goes back through the lane logic
		if (mem_grab)
		begin
			rdata_o <= mem_data_i;
		end
		if (finish)
		begin
			wd_o    <= wd_i;
			wdata_o <= (is_load && !exc_o) ? load_data_i : wdata_i;
		end
	end

endmodule

`default_nettype wire

//--- mem_stage.sv
`default_nettype none

module mem_stage
	import mips_mem_pkg::*;
	import mips_except_pkg::*;
#(
	parameter int unsigned NUM_HW_INT = 8
)
(
	input  wire                   clk,
	input  wire                   reset_i,

	// execute side
	input  logic                  op_req_i,
	output logic                  op_ack_o,
	input  mem_op_t               op_i,
	input  addr_t                 addr_i,
	input  word_t                 reg2_i,
	input  word_t                 wdata_i,
	input  reg_addr_t             wd_i,
	input  logic                  wreg_i,
	input  exc_flags_t            exc_flags_i,

	// interrupts and status register
	input  logic [NUM_HW_INT-1:0] hw_int_i,
	input  logic                  cfg_we_i,
	input  word_t                 cfg_data_i,
	output word_t                 status_o,

	// RAM side
	output logic                  mem_req_o,
	input  logic                  mem_ack_i,
	output addr_t                 mem_addr_o,
	output logic                  mem_we_o,
	output byte_sel_t             mem_sel_o,
	output word_t                 mem_data_o,
	input  word_t                 mem_data_i,

	// results
	output reg_addr_t             wd_o,
	output logic                  wreg_o,
	output word_t                 wdata_o,
	output logic                  exc_o,
	output exc_code_t             exc_code_o,
	output addr_t                 badaddr_o
);

	byte_sel_t sel;
	word_t     store_data;
	word_t     load_data;
	word_t     rdata;
	logic      is_store;
	logic      is_mem;
	logic      misaligned;
	logic      take_exc;
	exc_code_t exc_code;
	addr_t     badaddr;

	load_store_align align_inst
	(
		.op_i         (op_i),
		.addr_i       (addr_i),
		.reg2_i       (reg2_i),
		.rdata_i      (rdata),
		.sel_o        (sel),
		.store_data_o (store_data),
		.load_data_o  (load_data),
		.is_store_o   (is_store),
		.is_mem_o     (is_mem),
		.misaligned_o (misaligned)
	);

	cp0_status_regs #(.NUM_HW_INT(NUM_HW_INT)) status_inst
	(
		.clk        (clk),
		.reset_i    (reset_i),
		.cfg_we_i   (cfg_we_i),
		.cfg_data_i (cfg_data_i),
		.status_o   (status_o)
	);

	except_resolve #(.NUM_HW_INT(NUM_HW_INT)) except_inst
	(
		.status_i     (status_o),
		.hw_int_i     (hw_int_i),
		.exc_flags_i  (exc_flags_i),
		.misaligned_i (misaligned),
		.is_store_i   (is_store),
		.addr_i       (addr_i),
		.take_exc_o   (take_exc),
		.exc_code_o   (exc_code),
		.badaddr_o    (badaddr)
	);

	mem_access_fsm fsm_inst
	(
		.clk          (clk),
		.reset_i      (reset_i),
		.op_req_i     (op_req_i),
		.op_ack_o     (op_ack_o),
		.wd_i         (wd_i),
		.wreg_i       (wreg_i),
		.wdata_i      (wdata_i),
		.is_mem_i     (is_mem),
		.is_store_i   (is_store),
		.sel_i        (sel),
		.store_data_i (store_data),
		.load_data_i  (load_data),
		.take_exc_i   (take_exc),
		.exc_code_i   (exc_code),
		.badaddr_i    (badaddr),
		.addr_i       (addr_i),
		.mem_req_o    (mem_req_o),
		.mem_ack_i    (mem_ack_i),
		.mem_addr_o   (mem_addr_o),
		.mem_we_o     (mem_we_o),
		.mem_sel_o    (mem_sel_o),
		.mem_data_o   (mem_data_o),
		.mem_data_i   (mem_data_i),
		.wd_o         (wd_o),
		.wreg_o       (wreg_o),
		.wdata_o      (wdata_o),
		.exc_o        (exc_o),
		.exc_code_o   (exc_code_o),
		.badaddr_o    (badaddr_o),
		.rdata_o      (rdata)
	);

endmodule

`default_nettype wire

//--- tb_ram_responder.sv
`default_nettype none

module tb_ram_responder
	import mips_mem_pkg::*;
(
	input  wire       clk,
	input  wire       reset_i,
	input  logic      mem_req_i,
	input  addr_t     mem_addr_i,
	input  logic      mem_we_i,
	input  byte_sel_t mem_sel_i,
	input  word_t     mem_data_i,
	output logic      mem_ack_o,
	output word_t     mem_data_o,
	output int        access_count_o
);

	word_t      mem [0:15];
	integer     seed;
	int         delay_left;
	logic [3:0] idx;

	assign idx = mem_addr_i[5:2];

	initial
	begin
		seed           = 82;
		delay_left     = -1;
		mem_ack_o      = 1'b0;
		mem_data_o     = '0;
		access_count_o = 0;
		// word index shows up in every byte
		for (int i = 0; i < 16; i++)
			mem[i] = 32'hE172_04F3 ^ {4{4'h0, 4'(i)}};
	end

	// one read or write, honoring the byte lanes
	task automatic serve_access();
		if (mem_we_i)
		begin
			for (int b = 0; b < 4; b++)
				if (mem_sel_i[b])
					mem[idx][8*b +: 8] = mem_data_i[8*b +: 8];
		end
		else
			mem_data_o = mem[idx];
		access_count_o = access_count_o + 1;
	endtask

	////////////////////////////////////////////////////////////
	// four-phase acknowledge with a random delay
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (reset_i)
		begin
			mem_ack_o  = 1'b0;
			delay_left = -1;
		end
		else if (mem_ack_o)
		begin
			// release once the stage drops its request
			if (!mem_req_i)
				mem_ack_o = 1'b0;
		end
		else if (mem_req_i)
		begin
			if (delay_left < 0)
				delay_left = $random(seed) & 3;
			if (delay_left == 0)
			begin
				serve_access();
				mem_ack_o  = 1'b1;
				delay_left = -1;
			end
			else
				delay_left = delay_left - 1;
		end
	end

endmodule

`default_nettype wire

//--- tb_mem_stage.sv
`default_nettype none

module tb_mem_stage
	import mips_mem_pkg::*;
	import mips_except_pkg::*;
();

	localparam int NUM_HW_INT  = 8;
	localparam int ACK_TIMEOUT = 50;
	localparam int MAX_ROWS    = 64;

	localparam exc_flags_t SYS_FLAG = exc_flags_t'(1 << FLAG_SYS);
	localparam exc_flags_t RI_FLAG  = exc_flags_t'(1 << FLAG_RI);
	localparam exc_flags_t OV_FLAG  = exc_flags_t'(1 << FLAG_OV);
	localparam exc_flags_t TR_FLAG  = exc_flags_t'(1 << FLAG_TR);

	typedef struct {
		logic       cfg_we;
		word_t      cfg_data;
		mem_op_t    op;
		addr_t      addr;
		word_t      reg2;
		word_t      wdata;
		logic [7:0] hw_int;
		exc_flags_t flags;
		word_t      exp_wdata;
		logic       exp_wreg;
		logic       exp_exc;
		exc_code_t  exp_code;
		addr_t      exp_badaddr;
		int         exp_accesses;
	} test_row_t;

	logic                  clk;
	logic                  reset_i;
	logic                  op_req_i;
	logic                  op_ack_o;
	mem_op_t               op_i;
	addr_t                 addr_i;
	word_t                 reg2_i;
	word_t                 wdata_i;
	reg_addr_t             wd_i;
	logic                  wreg_i;
	exc_flags_t            exc_flags_i;
	logic [NUM_HW_INT-1:0] hw_int_i;
	logic                  cfg_we_i;
	word_t                 cfg_data_i;
	word_t                 status_o;
	logic                  mem_req_o;
	logic                  mem_ack_i;
	addr_t                 mem_addr_o;
	logic                  mem_we_o;
	byte_sel_t             mem_sel_o;
	word_t                 mem_data_o;
	word_t                 mem_data_i;
	reg_addr_t             wd_o;
	logic                  wreg_o;
	word_t                 wdata_o;
	logic                  exc_o;
	exc_code_t             exc_code_o;
	addr_t                 badaddr_o;
	int                    access_count;

	test_row_t rows [0:MAX_ROWS-1];
	int        num_rows;
	int        error_count;
	int        failed_tests;
	logic      row_bad;
	logic      stalled;

	mem_stage #(.NUM_HW_INT(NUM_HW_INT)) mem_stage_inst
	(
		.clk         (clk),
		.reset_i     (reset_i),
		.op_req_i    (op_req_i),
		.op_ack_o    (op_ack_o),
		.op_i        (op_i),
		.addr_i      (addr_i),
		.reg2_i      (reg2_i),
		.wdata_i     (wdata_i),
		.wd_i        (wd_i),
		.wreg_i      (wreg_i),
		.exc_flags_i (exc_flags_i),
		.hw_int_i    (hw_int_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_data_i  (cfg_data_i),
		.status_o    (status_o),
		.mem_req_o   (mem_req_o),
		.mem_ack_i   (mem_ack_i),
		.mem_addr_o  (mem_addr_o),
		.mem_we_o    (mem_we_o),
		.mem_sel_o   (mem_sel_o),
		.mem_data_o  (mem_data_o),
		.mem_data_i  (mem_data_i),
		.wd_o        (wd_o),
		.wreg_o      (wreg_o),
		.wdata_o     (wdata_o),
		.exc_o       (exc_o),
		.exc_code_o  (exc_code_o),
		.badaddr_o   (badaddr_o)
	);

	tb_ram_responder ram_model_inst
	(
		.clk            (clk),
		.reset_i        (reset_i),
		.mem_req_i      (mem_req_o),
		.mem_addr_i     (mem_addr_o),
		.mem_we_i       (mem_we_o),
		.mem_sel_i      (mem_sel_o),
		.mem_data_i     (mem_data_o),
		.mem_ack_o      (mem_ack_i),
		.mem_data_o     (mem_data_i),
		.access_count_o (access_count)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// table construction
	////////////////////////////////////////////////////////////

	task automatic add_row(input logic cfg_we, input word_t cfg_data, input mem_op_t op,
		input addr_t addr, input word_t reg2, input word_t wdata, input logic [7:0] hw_int,
		input exc_flags_t flags, input word_t exp_wdata, input logic exp_wreg,
		input logic exp_exc, input exc_code_t exp_code, input addr_t exp_badaddr,
		input int exp_accesses);
		test_row_t r;
		r.cfg_we       = cfg_we;
		r.cfg_data     = cfg_data;
		r.op           = op;
		r.addr         = addr;
		r.reg2         = reg2;
		r.wdata        = wdata;
		r.hw_int       = hw_int;
		r.flags        = flags;
		r.exp_wdata    = exp_wdata;
		r.exp_wreg     = exp_wreg;
		r.exp_exc      = exp_exc;
		r.exp_code     = exp_code;
		r.exp_badaddr  = exp_badaddr;
		r.exp_accesses = exp_accesses;
		rows[num_rows] = r;
		num_rows++;
	endtask

	task automatic load_case(input mem_op_t op, input addr_t addr, input word_t expected);
		add_row(1'b0, '0, op, addr, '0, 32'h5A5A_5A5A, '0, '0,
			expected, 1'b1, 1'b0, EXC_INT, '0, 1);
	endtask

	// stores pass wdata_i through and never write a register
	task automatic store_case(input mem_op_t op, input addr_t addr, input word_t reg2);
		add_row(1'b0, '0, op, addr, reg2, 32'h3C3C_3C3C, '0, '0,
			32'h3C3C_3C3C, 1'b0, 1'b0, EXC_INT, '0, 1);
	endtask

	task automatic fault_case(input mem_op_t op, input addr_t addr, input exc_flags_t flags,
		input exc_code_t code, input addr_t badaddr);
		add_row(1'b0, '0, op, addr, 32'hFFFF_FFFF, 32'hDEAD_BEEF, '0, flags,
			32'hDEAD_BEEF, 1'b0, 1'b1, code, badaddr, 0);
	endtask

	// word load from address 0 under a new status value
	task automatic irq_case(input word_t status, input logic [7:0] lines, input logic taken);
		add_row(1'b1, status, OP_LW, 32'h0, '0, 32'h5A5A_5A5A, lines, '0,
			taken ? 32'h5A5A_5A5A : 32'hE172_04F3, !taken, taken, EXC_INT, '0,
			taken ? 0 : 1);
	endtask

	task automatic build_table();
		// word 2 holds e37006f1
		load_case(OP_LB,  32'h08, 32'hFFFF_FFF1);
		load_case(OP_LB,  32'h09, 32'h0000_0006);
		load_case(OP_LB,  32'h0A, 32'h0000_0070);
		load_case(OP_LB,  32'h0B, 32'hFFFF_FFE3);
		load_case(OP_LBU, 32'h08, 32'h0000_00F1);
		load_case(OP_LBU, 32'h09, 32'h0000_0006);
		load_case(OP_LBU, 32'h0A, 32'h0000_0070);
		load_case(OP_LBU, 32'h0B, 32'h0000_00E3);
		load_case(OP_LH,  32'h08, 32'h0000_06F1);
		load_case(OP_LH,  32'h0A, 32'hFFFF_E370);
		load_case(OP_LHU, 32'h08, 32'h0000_06F1);
		load_case(OP_LHU, 32'h0A, 32'h0000_E370);
		load_case(OP_LW,  32'h08, 32'hE370_06F1);
		// stores into word 5 with a whole-word readback after each
		store_case(OP_SW, 32'h14, 32'h1122_3344);
		load_case(OP_LW,  32'h14, 32'h1122_3344);
		store_case(OP_SB, 32'h14, 32'h1234_56AA);
		load_case(OP_LW,  32'h14, 32'h1122_33AA);
		store_case(OP_SB, 32'h15, 32'h1234_56BB);
		load_case(OP_LW,  32'h14, 32'h1122_BBAA);
		store_case(OP_SB, 32'h16, 32'h1234_56CC);
		load_case(OP_LW,  32'h14, 32'h11CC_BBAA);
		store_case(OP_SB, 32'h17, 32'h1234_56DD);
		load_case(OP_LW,  32'h14, 32'hDDCC_BBAA);
		store_case(OP_SH, 32'h14, 32'h9ABC_5566);
		load_case(OP_LW,  32'h14, 32'hDDCC_5566);
		store_case(OP_SH, 32'h16, 32'h9ABC_7788);
		load_case(OP_LW,  32'h14, 32'h7788_5566);
		// alignment faults
		fault_case(OP_LH, 32'h09, '0, EXC_ADEL, 32'h09);
		fault_case(OP_LW, 32'h0A, '0, EXC_ADEL, 32'h0A);
		fault_case(OP_SH, 32'h0B, '0, EXC_ADES, 32'h0B);
		fault_case(OP_SW, 32'h09, '0, EXC_ADES, 32'h09);
		load_case(OP_LW,  32'h08, 32'hE370_06F1);
		// line 2 taken first and then blocked by each condition in turn
		irq_case(32'h0000_0401, 8'h04, 1'b1);
		irq_case(32'h0000_0403, 8'h04, 1'b0);
		irq_case(32'h0000_0405, 8'h04, 1'b0);
		irq_case(32'h0000_0400, 8'h04, 1'b0);
		irq_case(32'h0000_0801, 8'h04, 1'b0);
		irq_case(32'h0000_8001, 8'h80, 1'b1);
		// interrupt outranks the incoming flags and the alignment fault
		add_row(1'b1, 32'h0000_0401, OP_SW, 32'h15, 32'hFFFF_FFFF, 32'hDEAD_BEEF, 8'h04,
			SYS_FLAG | TR_FLAG, 32'hDEAD_BEEF, 1'b0, 1'b1, EXC_INT, '0, 0);
		irq_case(32'h0000_0000, 8'h80, 1'b0);
		// incoming flags beat alignment faults
		fault_case(OP_SW, 32'h15, SYS_FLAG, EXC_SYS, '0);
		fault_case(OP_SH, 32'h14, OV_FLAG, EXC_OV, '0);
		fault_case(OP_SB, 32'h17, SYS_FLAG | OV_FLAG, EXC_SYS, '0);
		fault_case(OP_LB, 32'h08, RI_FLAG | TR_FLAG, EXC_RI, '0);
		fault_case(OP_LW, 32'h0A, TR_FLAG, EXC_TR, '0);
		load_case(OP_LW,  32'h14, 32'h7788_5566);
		add_row(1'b0, '0, OP_NONE, 32'h0000_0041, '0, 32'hCAFE_F00D, '0, '0,
			32'hCAFE_F00D, 1'b1, 1'b0, EXC_INT, '0, 0);
	endtask

	////////////////////////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input int test, input string what, input word_t got,
		input word_t expected);
		$display("ERROR at time %0t: test %0d %s is %h, expected %h",
			$time, test, what, got, expected);
		error_count++;
		row_bad = 1'b1;
	endtask

	task automatic wait_for_ack(input logic level, output logic reached);
		int cycles;
		cycles = 0;
		while (op_ack_o !== level && cycles < ACK_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		reached = (op_ack_o === level);
	endtask

	task automatic report_stall(input int test, input logic level);
		if (mem_req_o === 1'b1 || mem_ack_i === 1'b1)
			$display("RAM handshake stalled in test %0d: mem_req_o %b, mem_ack_i %b",
				test, mem_req_o, mem_ack_i);
		else if (level)
			$display("execute handshake stalled in test %0d: op_ack_o never rose", test);
		else
			$display("execute handshake stalled in test %0d: op_ack_o stayed high", test);
		error_count++;
		row_bad = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		test_row_t cur;
		int        count_before;
		int        i;
		logic      reached;
		clk          = 1'b0;
		reset_i      = 1'b1;
		op_req_i     = 1'b0;
		op_i         = OP_NONE;
		addr_i       = '0;
		reg2_i       = '0;
		wdata_i      = '0;
		wd_i         = '0;
		wreg_i       = 1'b0;
		exc_flags_i  = '0;
		hw_int_i     = '0;
		cfg_we_i     = 1'b0;
		cfg_data_i   = '0;
		num_rows     = 0;
		error_count  = 0;
		failed_tests = 0;
		stalled      = 1'b0;
		build_table();

		repeat (16) @(negedge clk);
		reset_i = 1'b0;
		if (op_ack_o !== 1'b0 || mem_req_o !== 1'b0 || mem_we_o !== 1'b0 ||
			exc_o !== 1'b0 || status_o !== '0)
		begin
			$display("ERROR at time %0t: outputs not cleared by reset", $time);
			error_count++;
		end

		i = 0;
		while (i < num_rows && !stalled)
		begin
			cur     = rows[i];
			row_bad = 1'b0;
			if (cur.cfg_we)
			begin
				cfg_we_i   = 1'b1;
				cfg_data_i = cur.cfg_data;
				@(negedge clk);
				cfg_we_i = 1'b0;
				if (status_o !== cur.cfg_data)
					report_mismatch(i, "status_o", status_o, cur.cfg_data);
			end
			op_i         = cur.op;
			addr_i       = cur.addr;
			reg2_i       = cur.reg2;
			wdata_i      = cur.wdata;
			wd_i         = reg_addr_t'(i);
			wreg_i       = 1'b1;
			hw_int_i     = cur.hw_int;
			exc_flags_i  = cur.flags;
			count_before = access_count;
			op_req_i     = 1'b1;
			wait_for_ack(1'b1, reached);
			if (!reached)
			begin
				report_stall(i, 1'b1);
				stalled = 1'b1;
			end
			else
			begin
				if (wdata_o !== cur.exp_wdata)
					report_mismatch(i, "wdata_o", wdata_o, cur.exp_wdata);
				if (wreg_o !== cur.exp_wreg)
					report_mismatch(i, "wreg_o", word_t'(wreg_o), word_t'(cur.exp_wreg));
				if (exc_o !== cur.exp_exc)
					report_mismatch(i, "exc_o", word_t'(exc_o), word_t'(cur.exp_exc));
				if (cur.exp_exc && exc_code_o !== cur.exp_code)
					report_mismatch(i, "exc_code_o", word_t'(exc_code_o),
						word_t'(cur.exp_code));
				if (badaddr_o !== cur.exp_badaddr)
					report_mismatch(i, "badaddr_o", badaddr_o, cur.exp_badaddr);
				if (wd_o !== reg_addr_t'(i))
					report_mismatch(i, "wd_o", word_t'(wd_o), word_t'(i));
				op_req_i = 1'b0;
				wait_for_ack(1'b0, reached);
				if (!reached)
				begin
					report_stall(i, 1'b0);
					stalled = 1'b1;
				end
				else if (access_count - count_before != cur.exp_accesses)
					report_mismatch(i, "RAM access count change",
						word_t'(access_count - count_before), word_t'(cur.exp_accesses));
			end
			if (row_bad)
				failed_tests++;
			$display("test %0d %s at %h: %s", i, cur.op.name(), cur.addr,
				row_bad ? "FAIL" : "ok");
			i++;
		end

		$display("%0d of %0d tests run, %0d failed, %0d errors",
			i, num_rows, failed_tests, error_count);
		if (stalled || error_count != 0)
			$display("Some tests failed");
		else
			$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
mips_mem_pkg.sv
mips_except_pkg.sv
load_store_align.sv
cp0_status_regs.sv
except_resolve.sv
mem_access_fsm.sv
mem_stage.sv
tb_ram_responder.sv
tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the mem_stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f tb.f --top-module tb_mem_stage -o sim_mem_stage

./obj_dir/sim_mem_stage > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

# the log decides the verdict
if grep -q "Some tests failed" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0
